// File: icache_sub.f
logic/icache_pkg.sv
logic/mem_pkg.sv
logic/icache_ctrl.sv
logic/icache_tag_store.sv
logic/icache_data_store.sv
logic/icache_top.sv
tests/icache_mem_model.sv
tests/icache_tb.sv

// File: Makefile
# Verilator build and run for the icache subsystem
VERILATOR ?= verilator
FILELIST  ?= icache_sub.f
TOP       ?= icache_tb
BUILD_DIR ?= obj_dir
SIM_BIN   ?= icache_sim
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0

.DEFAULT_GOAL := help
.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run the testbench, check $(LOG)"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "variables: VERILATOR FILELIST TOP BUILD_DIR SIM_BIN LOG VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(BUILD_DIR) -o $(SIM_BIN)
	./$(BUILD_DIR)/$(SIM_BIN) 2>&1 | tee $(LOG)
	@grep -qx 'TEST OK' $(LOG) || (echo "simulation did not pass, see $(LOG)"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: tests/icache_tb.sv
//------------------------------------------------
// icache testbench, random fetch stream against the memory model
// checks sweep, ordering, hit latency, refill address and stalls
//------------------------------------------------

module icache_tb;
  timeunit 1ns;
  timeprecision 1ps;
  import icache_pkg::*;
  import mem_pkg::*;

  localparam int INDEX_W = INDEX_W_DEF;
  localparam int OFFSET_W = OFFSET_W_DEF;
  localparam int TAG_W = ADDR_W - INDEX_W - OFFSET_W - 2;
  localparam int LINES = 2 ** INDEX_W;
  localparam int TIMEOUT = 200;
  localparam int RANDOM_REQS = 300;
  localparam word_t FILL_PATTERN = 32'h5a3c96e1;

  logic              clk;
  logic              rst;
  logic              req_valid;
  logic [ADDR_W-1:0] req_addr;
  logic              req_ready;
  logic              rsp_ready;
  logic              rsp_valid;
  word_t             rsp_data;
  logic              mem_stb;
  word_addr_t        mem_addr;
  word_t             mem_data;
  logic              mem_ack;

  // reference model, updated when a request is accepted
  logic [ADDR_W-1:0] sent_q [$];
  logic              ref_valid [LINES];
  logic [TAG_W-1:0]  ref_tag [LINES];

  logic [31:0]       lfsr = 32'he996c3a5;
  logic              stall_on = 1'b0;
  logic              reset_seen = 1'b0;
  logic              expect_hit = 1'b0;
  logic              expect_miss = 1'b0;
  logic              held = 1'b0;
  word_t             held_data;
  word_addr_t        miss_line;
  logic [INDEX_W-1:0] idx;
  logic [TAG_W-1:0]  tag;
  logic [ADDR_W-1:0] old_addr;
  int                sweep_left = 0;
  int                hits = 0;
  int                misses = 0;
  int                stalls = 0;

  icache_top #(.INDEX_W(INDEX_W), .OFFSET_W(OFFSET_W)) icache_top_inst (.*);

  icache_mem_model #(
    .OFFSET_W    (OFFSET_W),
    .FILL_PATTERN(FILL_PATTERN)
  ) mem_model_inst (.*);

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  //------------------------------------------------
  // helpers
  //------------------------------------------------

  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return s[0] ? ((s >> 1) ^ 32'h80200003) : (s >> 1);
  endfunction

  // memory content rule, word address xor a fixed pattern
  function automatic word_t word_at(input word_addr_t a);
    return word_t'(a) ^ FILL_PATTERN;
  endfunction

  function automatic logic [ADDR_W-1:0] line_addr(input int t, input int i, input int w);
    return {TAG_W'(t), INDEX_W'(i), OFFSET_W'(w), 2'b00};
  endfunction

  task automatic stop_on_error(input string why);
    $display("%s", why);
    $display("TEST FAILED");
    $fatal(1);
  endtask

  task automatic value_error(input string name, input logic [31:0] exp, input logic [31:0] act);
    stop_on_error($sformatf("ERR %0d ns %s expected %h actual %h", $time, name, exp, act));
  endtask

  task automatic take_bits(input int n, output logic [31:0] bits);
    bits = '0;
    repeat (n) begin
      lfsr = lfsr_next(lfsr);
      bits = {bits[30:0], lfsr[0]};
    end
  endtask

  // four tags over four indices, so lines conflict often
  task automatic pick_addr(output logic [ADDR_W-1:0] addr);
    logic [31:0] bits;
    take_bits(6 + OFFSET_W, bits);
    addr = line_addr(int'(bits[1:0]) * 3 + 1, int'(bits[3:2]) * 5 + 2, int'(bits >> 6));
    addr[1:0] = bits[5:4];
  endtask

  task automatic drive_ready();
    logic [31:0] bits;
    if (stall_on) begin
      take_bits(2, bits);
      rsp_ready <= (bits[1:0] != 2'b00);
    end else begin
      rsp_ready <= 1'b1;
    end
  endtask

  task automatic expect_idle();
    assert (!req_ready) else value_error("req_ready", 32'd0, 32'(req_ready));
    assert (!rsp_valid) else value_error("rsp_valid", 32'd0, 32'(rsp_valid));
    assert (!mem_stb) else value_error("mem_stb", 32'd0, 32'(mem_stb));
  endtask

  task automatic send_req(input logic [ADDR_W-1:0] addr);
    int   waited;
    logic taken;
    req_valid <= 1'b1;
    req_addr <= addr;
    waited = 0;
    taken = 1'b0;
    while (!taken && waited < TIMEOUT) begin
      @(posedge clk);
      taken = req_ready;
      drive_ready();
      waited++;
    end
    if (!taken) stop_on_error("request was not accepted before the timeout");
    req_valid <= 1'b0;
  endtask

  //------------------------------------------------
  // checker, sees the values from just before each edge
  //------------------------------------------------

  always @(posedge clk) begin
    if (rst) begin
      if (reset_seen) expect_idle();
      reset_seen = 1'b1;
      sweep_left = LINES;
      expect_hit = 1'b0;
      expect_miss = 1'b0;
      held = 1'b0;
      foreach (ref_valid[i]) ref_valid[i] = 1'b0;
    end else begin
      if (sweep_left > 0) begin
        expect_idle();
        sweep_left--;
      end
      if (expect_hit) begin
        assert (rsp_valid) else value_error("rsp_valid", 32'd1, 32'(rsp_valid));
        assert (!mem_stb) else value_error("mem_stb", 32'd0, 32'(mem_stb));
      end
      if (expect_miss) begin
        assert (!rsp_valid) else value_error("rsp_valid", 32'd0, 32'(rsp_valid));
        assert (mem_stb) else value_error("mem_stb", 32'd1, 32'(mem_stb));
        assert (mem_addr == miss_line) else value_error("mem_addr", 32'(miss_line), 32'(mem_addr));
      end
      expect_hit = 1'b0;
      expect_miss = 1'b0;
      if (!rsp_ready) begin
        assert (!req_ready) else value_error("req_ready", 32'd0, 32'(req_ready));
      end
      if (held) begin
        assert (rsp_valid) else value_error("rsp_valid", 32'd1, 32'(rsp_valid));
        assert (rsp_data == held_data) else value_error("rsp_data", held_data, rsp_data);
      end
      held = rsp_valid & ~rsp_ready;
      held_data = rsp_data;
      if (held) stalls++;
      if (rsp_valid && rsp_ready) begin
        if (sent_q.size() == 0) stop_on_error("response arrived with no request outstanding");
        old_addr = sent_q.pop_front();
        assert (rsp_data == word_at(old_addr[ADDR_W-1:2]))
          else value_error("rsp_data", word_at(old_addr[ADDR_W-1:2]), rsp_data);
      end
      if (req_valid && req_ready) begin
        sent_q.push_back(req_addr);
        idx = req_addr[OFFSET_W+2 +: INDEX_W];
        tag = req_addr[INDEX_W+OFFSET_W+2 +: TAG_W];
        expect_hit = ref_valid[idx] && (ref_tag[idx] == tag);
        expect_miss = !expect_hit;
        miss_line = {tag, idx, {OFFSET_W{1'b0}}};
        if (expect_hit) hits++;
        else misses++;
        ref_valid[idx] = 1'b1;
        ref_tag[idx] = tag;
      end
    end
  end

  //------------------------------------------------
  // stimulus
  //------------------------------------------------

  initial begin
    logic [ADDR_W-1:0] addr;
    logic [31:0]       gap;
    int                waited;
    rst <= 1'b1;
    req_valid <= 1'b0;
    req_addr <= '0;
    rsp_ready <= 1'b1;
    repeat (3) @(posedge clk);
    rst <= 1'b0;
    waited = 0;
    while (!req_ready && waited < LINES + TIMEOUT) begin
      @(posedge clk);
      waited++;
    end
    if (!req_ready) stop_on_error("req_ready never rose after the invalidate sweep");
    // same index with tag 1, tag 4, tag 1 again, then a hit
    send_req(line_addr(1, 2, 3));
    send_req(line_addr(4, 2, 5));
    send_req(line_addr(1, 2, 1));
    send_req(line_addr(1, 2, 6));
    stall_on = 1'b1;
    repeat (RANDOM_REQS) begin
      pick_addr(addr);
      send_req(addr);
      take_bits(2, gap);
      if (gap[1:0] == 2'b00) begin
        @(posedge clk);
        drive_ready();
      end
    end
    stall_on = 1'b0;
    rsp_ready <= 1'b1;
    waited = 0;
    while (sent_q.size() != 0 && waited < TIMEOUT) begin
      @(negedge clk);
      waited++;
    end
    if (sent_q.size() != 0) stop_on_error("responses still outstanding at the end of the run");
    if (hits == 0 || misses == 0 || stalls == 0) begin
      stop_on_error("stimulus did not produce hits, misses and stalls");
    end else begin
      $display("TEST OK");
      $finish;
    end
  end

endmodule

// File: tests/icache_mem_model.sv
//------------------------------------------------
// main memory model for the icache refill port
// answers each strobe with one line burst after a random delay
//------------------------------------------------

module icache_mem_model #(
  parameter int OFFSET_W = icache_pkg::OFFSET_W_DEF,
  parameter mem_pkg::word_t FILL_PATTERN = 32'h0
) (
  input  logic                clk,
  input  logic                rst,
  input  logic                mem_stb,
  input  mem_pkg::word_addr_t mem_addr,
  output mem_pkg::word_t      mem_data,
  output logic                mem_ack
);
  timeunit 1ns;
  timeprecision 1ps;
  import mem_pkg::*;

  localparam int LINE_WORDS = 2 ** OFFSET_W;

  logic [31:0] lfsr = 32'he996c3a5;
  word_addr_t  line;
  int          delay;

  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return s[0] ? ((s >> 1) ^ 32'h80200003) : (s >> 1);
  endfunction

  // every address bit reaches the data word
  function automatic word_t word_at(input word_addr_t a);
    return word_t'(a) ^ FILL_PATTERN;
  endfunction

  initial begin
    mem_ack <= 1'b0;
    mem_data <= '0;
    forever begin
      @(posedge clk);
      if (!rst && mem_stb) begin
        line = mem_addr;
        // 0 to 7 idle cycles, one lfsr step per bit
        delay = 0;
        repeat (3) begin
          lfsr = lfsr_next(lfsr);
          delay = delay * 2 + int'(lfsr[0]);
        end
        repeat (delay) @(posedge clk);
        for (int beat = 0; beat < LINE_WORDS; beat++) begin
          mem_ack <= 1'b1;
          mem_data <= word_at(line + word_addr_t'(beat));
          @(posedge clk);
        end
        mem_ack <= 1'b0;
      end
    end
  end

endmodule

// File: logic/icache_top.sv
//------------------------------------------------
// icache subsystem top, controller plus tag and data stores
// fetch side streams in, refill bursts out to main memory
//------------------------------------------------

module icache_top #(
  parameter int INDEX_W = icache_pkg::INDEX_W_DEF,
  parameter int OFFSET_W = icache_pkg::OFFSET_W_DEF
) (
  input  logic                          clk,
  input  logic                          rst,
  // fetch request stream
  input  logic                          req_valid,
  input  logic [icache_pkg::ADDR_W-1:0] req_addr,
  output logic                          req_ready,
  // instruction response stream
  input  logic                          rsp_ready,
  output logic                          rsp_valid,
  output mem_pkg::word_t                rsp_data,
  // main memory refill bus
  output logic                          mem_stb,
  output mem_pkg::word_addr_t           mem_addr,
  input  mem_pkg::word_t                mem_data,
  input  logic                          mem_ack
);
  import icache_pkg::*;

  localparam int TAG_W = ADDR_W - INDEX_W - OFFSET_W - 2;

  logic                rd_en;
  logic [INDEX_W-1:0]  rd_index;
  logic [OFFSET_W-1:0] rd_word;
  logic                wr_en;
  logic                wr_clear;
  logic [INDEX_W-1:0]  wr_index;
  logic [OFFSET_W-1:0] wr_word;
  logic [TAG_W-1:0]    wr_tag;
  logic                hit;

  icache_ctrl #(
    .INDEX_W (INDEX_W),
    .OFFSET_W(OFFSET_W)
  ) icache_ctrl_inst (
    .clk      (clk),
    .rst      (rst),
    .req_valid(req_valid),
    .req_addr (req_addr),
    .req_ready(req_ready),
    .rsp_ready(rsp_ready),
    .rsp_valid(rsp_valid),
    .hit      (hit),
    .mem_stb  (mem_stb),
    .mem_addr (mem_addr),
    .mem_ack  (mem_ack),
    .rd_en    (rd_en),
    .rd_index (rd_index),
    .rd_word  (rd_word),
    .wr_en    (wr_en),
    .wr_clear (wr_clear),
    .wr_index (wr_index),
    .wr_word  (wr_word),
    .wr_tag   (wr_tag)
  );

  // wr_tag always carries the lookup-stage tag
  icache_tag_store #(
    .INDEX_W (INDEX_W),
    .OFFSET_W(OFFSET_W)
  ) icache_tag_store_inst (
    .clk       (clk),
    .rd_en     (rd_en),
    .rd_index  (rd_index),
    .wr_en     (wr_en),
    .wr_clear  (wr_clear),
    .wr_index  (wr_index),
    .wr_tag    (wr_tag),
    .lookup_tag(wr_tag),
    .hit       (hit)
  );

  // sweep clears only touch the tag store
  icache_data_store #(
    .INDEX_W (INDEX_W),
    .OFFSET_W(OFFSET_W)
  ) icache_data_store_inst (
    .clk     (clk),
    .rd_en   (rd_en),
    .rd_index(rd_index),
    .rd_word (rd_word),
    .wr_en   (wr_en & ~wr_clear),
    .wr_index(wr_index),
    .wr_word (wr_word),
    .wr_data (mem_data),
    .rd_data (rsp_data)
  );

endmodule

// File: logic/icache_data_store.sv
//------------------------------------------------
// instruction word array, one registered read port
// and one refill write port
//------------------------------------------------

module icache_data_store #(
  parameter int INDEX_W = icache_pkg::INDEX_W_DEF,
  parameter int OFFSET_W = icache_pkg::OFFSET_W_DEF
) (
  input  logic                clk,
  // read port
  input  logic                rd_en,
  input  logic [INDEX_W-1:0]  rd_index,
  input  logic [OFFSET_W-1:0] rd_word,
  // refill write port
  input  logic                wr_en,
  input  logic [INDEX_W-1:0]  wr_index,
  input  logic [OFFSET_W-1:0] wr_word,
  input  mem_pkg::word_t      wr_data,
  output mem_pkg::word_t      rd_data
);
  import mem_pkg::*;

  localparam int WORDS = 2 ** (INDEX_W + OFFSET_W);

  // line index on top, word within the line below
  typedef logic [INDEX_W+OFFSET_W-1:0] slot_t;

  word_t data_mem [WORDS];

  slot_t rd_slot;
  slot_t wr_slot;

  assign rd_slot = {rd_index, rd_word};
  assign wr_slot = {wr_index, wr_word};

  always_ff @(posedge clk) begin
    if (rd_en) begin
      rd_data <= data_mem[rd_slot];
    end
    if (wr_en) begin
      data_mem[wr_slot] <= wr_data;
    end
  end

endmodule

// File: logic/icache_tag_store.sv
//------------------------------------------------
// valid and tag arrays for the direct-mapped icache
// registered read, hit is compared after the register
//------------------------------------------------

module icache_tag_store #(
  parameter int INDEX_W = icache_pkg::INDEX_W_DEF,
  parameter int OFFSET_W = icache_pkg::OFFSET_W_DEF,
  localparam int TAG_W = icache_pkg::ADDR_W - INDEX_W - OFFSET_W - 2
) (
  input  logic               clk,
  // read port
  input  logic               rd_en,
  input  logic [INDEX_W-1:0] rd_index,
  // write port
  input  logic               wr_en,
  input  logic               wr_clear,
  input  logic [INDEX_W-1:0] wr_index,
  input  logic [TAG_W-1:0]   wr_tag,
  // tag held in the lookup stage
  input  logic [TAG_W-1:0]   lookup_tag,
  output logic               hit
);

  localparam int LINES = 2 ** INDEX_W;

  typedef logic [TAG_W-1:0] tag_t;

  logic valid_mem [LINES];
  tag_t tag_mem [LINES];

  logic valid_q;
  tag_t tag_q;

  //------------------------------------------------
  // valid bits
  //------------------------------------------------

  always_ff @(posedge clk) begin
    if (rd_en) begin
      valid_q <= valid_mem[rd_index];
    end
    // a clear invalidates, a refill validates
    if (wr_en) begin
      valid_mem[wr_index] <= ~wr_clear;
    end
  end

  //------------------------------------------------
  // tags
  //------------------------------------------------

  always_ff @(posedge clk) begin
    if (rd_en) begin
      tag_q <= tag_mem[rd_index];
    end
    // tag content is don't care on a clear
    if (wr_en) begin
      tag_mem[wr_index] <= wr_tag;
    end
  end

  assign hit = valid_q & (tag_q == lookup_tag);

endmodule

// File: logic/icache_ctrl.sv
//------------------------------------------------
// icache controller with the invalidate sweep, the lookup
// stage, the line refill and the re-read after refill
//------------------------------------------------

module icache_ctrl #(
  parameter int INDEX_W = icache_pkg::INDEX_W_DEF,
  parameter int OFFSET_W = icache_pkg::OFFSET_W_DEF,
  localparam int TAG_W = icache_pkg::ADDR_W - INDEX_W - OFFSET_W - 2
) (
  input  logic                         clk,
  input  logic                         rst,
  // fetch request stream
  input  logic                         req_valid,
  input  logic [icache_pkg::ADDR_W-1:0] req_addr,
  output logic                         req_ready,
  // instruction response stream
  input  logic                         rsp_ready,
  output logic                         rsp_valid,
  // from tag store
  input  logic                         hit,
  // refill bus
  output logic                         mem_stb,
  output mem_pkg::word_addr_t          mem_addr,
  input  logic                         mem_ack,
  // store read port
  output logic                         rd_en,
  output logic [INDEX_W-1:0]           rd_index,
  output logic [OFFSET_W-1:0]          rd_word,
  // store write port
  output logic                         wr_en,
  output logic                         wr_clear,
  output logic [INDEX_W-1:0]           wr_index,
  output logic [OFFSET_W-1:0]          wr_word,
  output logic [TAG_W-1:0]             wr_tag
);
  import icache_pkg::*;

  typedef logic [TAG_W-1:0] tag_t;
  typedef logic [INDEX_W-1:0] index_t;
  typedef logic [OFFSET_W-1:0] offset_t;

  ctrl_state_t state;
  index_t      sweep_cnt;

  // lookup stage
  logic    lk_valid;
  tag_t    lk_tag;
  index_t  lk_index;
  offset_t lk_word;

  // refill bookkeeping
  offset_t fill_cnt;
  logic    ack_d;

  tag_t    req_tag;
  index_t  req_index;
  offset_t req_word;

  logic sweeping;
  logic running;
  logic refilling;
  logic rereading;
  logic miss;
  logic fill_last;

  // byte select bits of req_addr are dropped
  assign req_word  = req_addr[OFFSET_W+1:2];
  assign req_index = req_addr[INDEX_W+OFFSET_W+1:OFFSET_W+2];
  assign req_tag   = req_addr[ADDR_W-1:INDEX_W+OFFSET_W+2];

  assign sweeping  = (state == st_sweep);
  assign running   = (state == st_run);
  assign refilling = (state == st_refill);
  assign rereading = (state == st_reread);

  assign miss      = lk_valid & ~hit;
  assign fill_last = mem_ack & (fill_cnt == '1);

  //------------------------------------------------
  // stream handshakes
  //------------------------------------------------

  // new request only when the held one can leave this cycle
  assign req_ready = rsp_ready & running & (~lk_valid | hit);
  assign rsp_valid = running & lk_valid & hit;

  //------------------------------------------------
  // state machine and sweep
  //------------------------------------------------

  always_ff @(posedge clk) begin
    if (rst) begin
      state     <= st_sweep;
      sweep_cnt <= '0;
    end else begin
      case (state)
        st_sweep: begin
          sweep_cnt <= sweep_cnt + 1'b1;
          if (sweep_cnt == '1) begin
            state <= st_run;
          end
        end
        st_run: begin
          if (miss) begin
            state <= st_refill;
          end
        end
        st_refill: begin
          if (fill_last) begin
            state <= st_reread;
          end
        end
        default: begin
          state <= st_run;
        end
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      lk_valid <= 1'b0;
    end else if (req_ready) begin
      lk_valid <= req_valid;
    end
  end

  always_ff @(posedge clk) begin
    if (req_ready) begin
      lk_tag   <= req_tag;
      lk_index <= req_index;
      lk_word  <= req_word;
    end
  end

  //------------------------------------------------
  // refill
  //------------------------------------------------

  // words arrive in order, so the counter restarts between bursts
  always_ff @(posedge clk) begin
    if (rst || !mem_ack) begin
      fill_cnt <= '0;
    end else begin
      fill_cnt <= fill_cnt + 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      ack_d <= 1'b0;
    end else begin
      ack_d <= mem_ack;
    end
  end

  // strobe holds until the first ack has been seen
  assign mem_stb  = (running | refilling) & miss & ~ack_d;
  assign mem_addr = {lk_tag, lk_index, offset_t'(0)};

  //------------------------------------------------
  // store addressing
  //------------------------------------------------

  assign rd_en    = req_ready | rereading;
  assign rd_index = rereading ? lk_index : req_index;
  assign rd_word  = rereading ? lk_word : req_word;

  assign wr_en    = sweeping | mem_ack;
  assign wr_clear = sweeping;
  assign wr_index = sweeping ? sweep_cnt : lk_index;
  assign wr_word  = fill_cnt;
  assign wr_tag   = lk_tag;

endmodule

// File: logic/mem_pkg.sv
//------------------------------------------------
// main memory bus types for the cache refill port
//------------------------------------------------

package mem_pkg;

  localparam int WORD_W = 32;

  // byte address minus the two byte select bits
  localparam int WORD_ADDR_W = 22;

  // instruction or memory data word
  typedef logic [WORD_W-1:0] word_t;

  // word address on the memory bus
  typedef logic [WORD_ADDR_W-1:0] word_addr_t;

endpackage

// File: logic/icache_pkg.sv
//------------------------------------------------
// instruction cache geometry and controller states
// imported by every cache module that needs them
//------------------------------------------------

package icache_pkg;

  // byte address space of the processor
  localparam int ADDR_W = 24;

  // default geometry is 512 lines of 8 words
  localparam int INDEX_W_DEF = 9;
  localparam int OFFSET_W_DEF = 3;

  // controller states
  // st_sweep   invalidate one line per cycle after reset
  // st_run     lookup stage active, hits stream out
  // st_refill  line burst from main memory
  // st_reread  read the buffered request again after refill
  typedef enum logic [1:0] {
    st_sweep,
    st_run,
    st_refill,
    st_reread
  } ctrl_state_t;

endpackage
